/* rtl/sd_host_pkg.sv */
`default_nettype none

package sd_host_pkg;

    // Register map, byte addresses
    localparam logic [31:0] addr_cmd     = 32'h00;
    localparam logic [31:0] addr_arg     = 32'h04;
    localparam logic [31:0] addr_control = 32'h08;
    localparam logic [31:0] addr_status  = 32'h0C;
    localparam logic [31:0] addr_clk_div = 32'h10;
    localparam logic [31:0] addr_resp_lo = 32'h14;
    localparam logic [31:0] addr_resp_hi = 32'h18;

    // Response type codes
    localparam logic [1:0] resp_none = 2'd0;
    localparam logic [1:0] resp_r1   = 2'd1;
    localparam logic [1:0] resp_r3   = 2'd2;

    // Status bit positions
    localparam int st_done      = 0;
    localparam int st_busy      = 1;
    localparam int st_timeout   = 2;
    localparam int st_crc_err   = 3;
    localparam int st_index_err = 4;

    localparam logic [7:0] clk_div_reset  = 8'd2;
    localparam logic [6:0] ncr_max        = 7'd64;
    localparam logic [6:0] cmd_token_bits = 7'd48;

    // Command engine states
    localparam logic [1:0] eng_idle    = 2'd0;
    localparam logic [1:0] eng_send    = 2'd1;
    localparam logic [1:0] eng_ack     = 2'd2;
    localparam logic [1:0] eng_release = 2'd3;

    // Bus serializer states
    localparam logic [2:0] ser_idle = 3'd0;
    localparam logic [2:0] ser_tx   = 3'd1;
    localparam logic [2:0] ser_wait = 3'd2;
    localparam logic [2:0] ser_rx   = 3'd3;
    localparam logic [2:0] ser_done = 3'd4;

    // 48-bit response token, raw as shifted in or split into fields
    typedef union packed {
        logic [47:0] raw;
        struct packed {
            logic        start;
            logic        dir;
            logic [5:0]  index;
            logic [31:0] arg;
            logic [6:0]  crc;
            logic        stop;
        } fields;
    } resp_token_t;

endpackage

`default_nettype wire

/* rtl/sd_reg_block.sv */
`default_nettype none

module sd_reg_block (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     we,
    input  logic                     re,
    input  logic [31:0]              waddr,
    input  logic [31:0]              raddr,
    input  logic [31:0]              wdata,
    input  logic                     cmd_ack,
    input  sd_host_pkg::resp_token_t resp_token,
    input  logic                     timeout_err,
    input  logic                     crc_err,
    input  logic                     index_err,
    output logic [31:0]              rdata,
    output logic                     interrupt,
    output logic                     cmd_req,
    output logic [5:0]               cmd_index,
    output logic [31:0]              cmd_arg,
    output logic [1:0]               resp_type,
    output logic                     index_check_en,
    output logic                     crc_check_en,
    output logic [7:0]               clk_div
);

    logic        done_st;
    logic        timeout_st;
    logic        crc_st;
    logic        index_st;
    logic [31:0] resp_arg;
    logic [6:0]  resp_crc;
    logic [5:0]  resp_index;
    logic [4:0]  status;
    logic        ack_take;
    logic        status_wr;

    // Engine acknowledge seen while the request is still up, one cycle per command
    assign ack_take  = cmd_ack && cmd_req;
    assign status_wr = we && (waddr == sd_host_pkg::addr_status);
    assign interrupt = done_st;

    always_comb begin
        status = '0;
        status[sd_host_pkg::st_done]      = done_st;
        status[sd_host_pkg::st_busy]      = cmd_req;
        status[sd_host_pkg::st_timeout]   = timeout_st;
        status[sd_host_pkg::st_crc_err]   = crc_st;
        status[sd_host_pkg::st_index_err] = index_st;
    end

    always_comb begin
        rdata = '0;
        if (re) begin
            case (raddr)
                sd_host_pkg::addr_cmd:
                    rdata = {20'd0, crc_check_en, index_check_en, resp_type, 2'd0, cmd_index};
                sd_host_pkg::addr_arg:     rdata = cmd_arg;
                sd_host_pkg::addr_control: rdata = {31'd0, cmd_req};
                sd_host_pkg::addr_status:  rdata = {27'd0, status};
                sd_host_pkg::addr_clk_div: rdata = {24'd0, clk_div};
                sd_host_pkg::addr_resp_lo: rdata = resp_arg;
                sd_host_pkg::addr_resp_hi: rdata = {17'd0, resp_crc, 2'd0, resp_index};
                default:                   rdata = '0;
            endcase
        end
    end

    // Command setup registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_index      <= '0;
            resp_type      <= sd_host_pkg::resp_r1;
            index_check_en <= 1'b1;
            crc_check_en   <= 1'b1;
            cmd_arg        <= '0;
            clk_div        <= sd_host_pkg::clk_div_reset;
        end else if (we) begin
            case (waddr)
                sd_host_pkg::addr_cmd: begin
                    cmd_index      <= wdata[5:0];
                    resp_type      <= wdata[9:8];
                    index_check_en <= wdata[10];
                    crc_check_en   <= wdata[11];
                end
                sd_host_pkg::addr_arg:     cmd_arg <= wdata;
                sd_host_pkg::addr_clk_div: clk_div <= wdata[7:0];
                default: ;
            endcase
        end
    end

    // Start bit and sticky status, the acknowledge wins over a clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_req    <= 1'b0;
            done_st    <= 1'b0;
            timeout_st <= 1'b0;
            crc_st     <= 1'b0;
            index_st   <= 1'b0;
        end else begin
            if (we && (waddr == sd_host_pkg::addr_control) && wdata[0] && !cmd_ack) begin
                cmd_req <= 1'b1;
            end
            if (status_wr) begin
                if (wdata[sd_host_pkg::st_done])      done_st    <= 1'b0;
                if (wdata[sd_host_pkg::st_timeout])   timeout_st <= 1'b0;
                if (wdata[sd_host_pkg::st_crc_err])   crc_st     <= 1'b0;
                if (wdata[sd_host_pkg::st_index_err]) index_st   <= 1'b0;
            end
            if (ack_take) begin
                cmd_req    <= 1'b0;
                done_st    <= 1'b1;
                timeout_st <= timeout_err;
                crc_st     <= crc_err;
                index_st   <= index_err;
            end
        end
    end

    // Response capture
    always_ff @(posedge clk) begin
        if (ack_take) begin
            resp_arg   <= resp_token.fields.arg;
            resp_crc   <= resp_token.fields.crc;
            resp_index <= resp_token.fields.index;
        end
    end

endmodule

`default_nettype wire

/* rtl/sd_cmd_engine.sv */
`default_nettype none

module sd_cmd_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_req,
    input  logic [5:0]               cmd_index,
    input  logic [31:0]              cmd_arg,
    input  logic [1:0]               resp_type,
    input  logic                     index_check_en,
    input  logic                     crc_check_en,
    input  logic                     tx_ack,
    input  sd_host_pkg::resp_token_t rx_token,
    input  logic                     rx_timeout,
    output logic                     cmd_ack,
    output sd_host_pkg::resp_token_t resp_token,
    output logic                     timeout_err,
    output logic                     crc_err,
    output logic                     index_err,
    output logic                     tx_req,
    output logic [47:0]              tx_token,
    output logic                     resp_expect
);

    logic [1:0]  state;
    logic        is_r1;
    logic        crc_bad;
    logic        index_bad;
    logic [39:0] cmd_head;

    // CRC7, polynomial x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // Start bit 0, direction bit 1 (host to card)
    assign cmd_head  = {2'b01, cmd_index, cmd_arg};
    assign is_r1     = (resp_type == sd_host_pkg::resp_r1);
    assign crc_bad   = (crc7(rx_token.raw[47:8]) != rx_token.fields.crc);
    assign index_bad = (rx_token.fields.index != cmd_index);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= sd_host_pkg::eng_idle;
            cmd_ack     <= 1'b0;
            tx_req      <= 1'b0;
            resp_expect <= 1'b0;
            timeout_err <= 1'b0;
            crc_err     <= 1'b0;
            index_err   <= 1'b0;
        end else begin
            case (state)
                sd_host_pkg::eng_idle: begin
                    if (cmd_req) begin
                        tx_req      <= 1'b1;
                        resp_expect <= is_r1 || (resp_type == sd_host_pkg::resp_r3);
                        state       <= sd_host_pkg::eng_send;
                    end
                end
                sd_host_pkg::eng_send: begin
                    if (tx_ack) begin
                        tx_req      <= 1'b0;
                        cmd_ack     <= 1'b1;
                        timeout_err <= rx_timeout;
                        // R3 and a timed out response skip both checks
                        crc_err     <= !rx_timeout && is_r1 && crc_check_en && crc_bad;
                        index_err   <= !rx_timeout && is_r1 && index_check_en && index_bad;
                        state       <= sd_host_pkg::eng_ack;
                    end
                end
                sd_host_pkg::eng_ack: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= sd_host_pkg::eng_release;
                    end
                end
                sd_host_pkg::eng_release: begin
                    if (!tx_ack) begin
                        state <= sd_host_pkg::eng_idle;
                    end
                end
                default: state <= sd_host_pkg::eng_idle;
            endcase
        end
    end

    // Token out and response in
    always_ff @(posedge clk) begin
        if ((state == sd_host_pkg::eng_idle) && cmd_req) begin
            tx_token <= {cmd_head, crc7(cmd_head), 1'b1};
        end
        if ((state == sd_host_pkg::eng_send) && tx_ack) begin
            resp_token <= rx_token;
        end
    end

endmodule

`default_nettype wire

/* rtl/sd_cmd_serdes.sv */
`default_nettype none

module sd_cmd_serdes (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [7:0]               clk_div,
    input  logic                     tx_req,
    input  logic [47:0]              tx_token,
    input  logic                     resp_expect,
    input  logic                     sd_cmd_in,
    output logic                     tx_ack,
    output sd_host_pkg::resp_token_t rx_token,
    output logic                     rx_timeout,
    output logic                     sd_clk,
    output logic                     sd_cmd_out,
    output logic                     sd_cmd_oe
);

    logic [2:0]  state;
    logic [7:0]  div_cnt;
    logic [6:0]  cnt;
    logic [47:0] tx_sr;
    logic        tick;
    logic        rise;
    logic        fall;
    logic        clk_on;

    assign clk_on = (state == sd_host_pkg::ser_tx) || (state == sd_host_pkg::ser_wait) ||
                    (state == sd_host_pkg::ser_rx);
    assign tick   = (div_cnt == clk_div);
    assign rise   = tick && !sd_clk;
    assign fall   = tick && sd_clk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sd_host_pkg::ser_idle;
            div_cnt    <= '0;
            sd_clk     <= 1'b0;
            sd_cmd_out <= 1'b1;
            sd_cmd_oe  <= 1'b0;
            cnt        <= '0;
            tx_ack     <= 1'b0;
            rx_timeout <= 1'b0;
        end else begin
            // SD clock only runs while a token is in progress
            if (!clk_on || tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
            if (!clk_on) begin
                sd_clk <= 1'b0;
            end else if (tick) begin
                sd_clk <= ~sd_clk;
            end

            case (state)
                sd_host_pkg::ser_idle: begin
                    if (tx_req) begin
                        cnt        <= '0;
                        sd_cmd_oe  <= 1'b1;
                        sd_cmd_out <= tx_token[47];
                        rx_timeout <= 1'b0;
                        state      <= sd_host_pkg::ser_tx;
                    end
                end
                sd_host_pkg::ser_tx: begin
                    if (rise) begin
                        cnt <= cnt + 7'd1;
                    end else if (fall && (cnt == sd_host_pkg::cmd_token_bits)) begin
                        // Last bit taken by the card, release the line
                        sd_cmd_oe  <= 1'b0;
                        sd_cmd_out <= 1'b1;
                        cnt        <= '0;
                        if (resp_expect) begin
                            state <= sd_host_pkg::ser_wait;
                        end else begin
                            tx_ack <= 1'b1;
                            state  <= sd_host_pkg::ser_done;
                        end
                    end else if (fall) begin
                        sd_cmd_out <= tx_sr[46];
                    end
                end
                sd_host_pkg::ser_wait: begin
                    if (rise && !sd_cmd_in) begin
                        cnt   <= 7'd1;
                        state <= sd_host_pkg::ser_rx;
                    end else if (rise) begin
                        cnt <= cnt + 7'd1;
                    end else if (fall && (cnt == sd_host_pkg::ncr_max)) begin
                        rx_timeout <= 1'b1;
                        tx_ack     <= 1'b1;
                        state      <= sd_host_pkg::ser_done;
                    end
                end
                sd_host_pkg::ser_rx: begin
                    if (rise) begin
                        cnt <= cnt + 7'd1;
                    end else if (fall && (cnt == sd_host_pkg::cmd_token_bits)) begin
                        tx_ack <= 1'b1;
                        state  <= sd_host_pkg::ser_done;
                    end
                end
                sd_host_pkg::ser_done: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= sd_host_pkg::ser_idle;
                    end
                end
                default: state <= sd_host_pkg::ser_idle;
            endcase
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge clk) begin
        if ((state == sd_host_pkg::ser_idle) && tx_req) begin
            tx_sr <= tx_token;
        end else if ((state == sd_host_pkg::ser_tx) && fall) begin
            tx_sr <= {tx_sr[46:0], 1'b1};
        end
        if (rise && ((state == sd_host_pkg::ser_rx) ||
                     ((state == sd_host_pkg::ser_wait) && !sd_cmd_in))) begin
            rx_token.raw <= {rx_token.raw[46:0], sd_cmd_in};
        end
    end

endmodule

`default_nettype wire

/* rtl/sd_host_top.sv */
`default_nettype none

module sd_host_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic        re,
    input  logic [31:0] waddr,
    input  logic [31:0] raddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        interrupt,
    output logic        sd_clk,
    output logic        sd_cmd_out,
    output logic        sd_cmd_oe,
    input  logic        sd_cmd_in
);

    // Register block to engine
    logic                     cmd_req;
    logic                     cmd_ack;
    logic [5:0]               cmd_index;
    logic [31:0]              cmd_arg;
    logic [1:0]               resp_type;
    logic                     index_check_en;
    logic                     crc_check_en;
    logic [7:0]               clk_div;
    sd_host_pkg::resp_token_t resp_token;
    logic                     timeout_err;
    logic                     crc_err;
    logic                     index_err;

    // Engine to serializer
    logic                     tx_req;
    logic                     tx_ack;
    logic [47:0]              tx_token;
    logic                     resp_expect;
    sd_host_pkg::resp_token_t rx_token;
    logic                     rx_timeout;

    sd_reg_block sd_reg_block_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .we             (we),
        .re             (re),
        .waddr          (waddr),
        .raddr          (raddr),
        .wdata          (wdata),
        .cmd_ack        (cmd_ack),
        .resp_token     (resp_token),
        .timeout_err    (timeout_err),
        .crc_err        (crc_err),
        .index_err      (index_err),
        .rdata          (rdata),
        .interrupt      (interrupt),
        .cmd_req        (cmd_req),
        .cmd_index      (cmd_index),
        .cmd_arg        (cmd_arg),
        .resp_type      (resp_type),
        .index_check_en (index_check_en),
        .crc_check_en   (crc_check_en),
        .clk_div        (clk_div)
    );

    sd_cmd_engine sd_cmd_engine_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_req        (cmd_req),
        .cmd_index      (cmd_index),
        .cmd_arg        (cmd_arg),
        .resp_type      (resp_type),
        .index_check_en (index_check_en),
        .crc_check_en   (crc_check_en),
        .tx_ack         (tx_ack),
        .rx_token       (rx_token),
        .rx_timeout     (rx_timeout),
        .cmd_ack        (cmd_ack),
        .resp_token     (resp_token),
        .timeout_err    (timeout_err),
        .crc_err        (crc_err),
        .index_err      (index_err),
        .tx_req         (tx_req),
        .tx_token       (tx_token),
        .resp_expect    (resp_expect)
    );

    sd_cmd_serdes sd_cmd_serdes_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_div     (clk_div),
        .tx_req      (tx_req),
        .tx_token    (tx_token),
        .resp_expect (resp_expect),
        .sd_cmd_in   (sd_cmd_in),
        .tx_ack      (tx_ack),
        .rx_token    (rx_token),
        .rx_timeout  (rx_timeout),
        .sd_clk      (sd_clk),
        .sd_cmd_out  (sd_cmd_out),
        .sd_cmd_oe   (sd_cmd_oe)
    );

endmodule

`default_nettype wire

/* testbench/sd_card_model.sv */
`default_nettype none

module sd_card_model (
    input  logic        clk,
    input  logic        sd_clk,
    input  logic        sd_cmd_out,
    input  logic        sd_cmd_oe,
    input  logic        answer,
    input  logic [47:0] resp_word,
    output logic        sd_cmd_in,
    output logic [47:0] cmd_token,
    output int          half_time
);

    logic [47:0] shift;
    int          bits;
    time         rise_time = 0;

    // High phase of sd_clk in time units
    always @(posedge sd_clk) begin
        rise_time = $time;
    end

    always @(negedge sd_clk) begin
        half_time = int'($time - rise_time);
    end

    // Start bit first, each bit placed on the falling clk edge after an sd_clk fall
    task automatic send_response();
        repeat (8) @(negedge sd_clk);
        for (int i = 47; i >= 0; i--) begin
            @(negedge clk);
            sd_cmd_in = resp_word[i];
            @(negedge sd_clk);
        end
        @(negedge clk);
        sd_cmd_in = 1'b1;
    endtask

    initial begin
        sd_cmd_in = 1'b1;
        cmd_token = '0;
        shift     = '0;
        bits      = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe) begin
                shift = {shift[46:0], sd_cmd_out};
                bits  = bits + 1;
                if (bits == 48) begin
                    cmd_token = shift;
                    bits      = 0;
                    if (answer) begin
                        send_response();
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/sd_host_assert.sv */
`default_nettype none

module sd_host_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        cmd_req,
    input logic        cmd_ack,
    input logic        tx_req,
    input logic        tx_ack,
    input logic [47:0] tx_token,
    input logic        sd_cmd_oe
);

    // Engine acknowledges only a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else $error("cmd_ack rose while cmd_req was low");

    tx_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req && !tx_ack |=> tx_req)
        else $error("tx_req dropped before tx_ack");

    tx_token_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req && $past(tx_req) |-> $stable(tx_token))
        else $error("tx_token changed while tx_req was high");

    // Line is released once the serializer reports back
    line_released: assert property (@(posedge clk) disable iff (!rst_n)
        tx_ack |-> !sd_cmd_oe)
        else $error("sd_cmd_oe high while tx_ack was high");

endmodule

bind sd_host_top sd_host_assert sd_host_assert_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .tx_token  (tx_token),
    .sd_cmd_oe (sd_cmd_oe)
);

`default_nettype wire

/* testbench/tb_sd_host.sv */
`default_nettype none

module tb_sd_host;

    localparam int max_lines = 16;
    localparam int fields    = 8;

    logic        clk;
    logic        rst_n;
    logic        we;
    logic        re;
    logic [31:0] waddr;
    logic [31:0] raddr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        interrupt;
    logic        sd_clk;
    logic        sd_cmd_out;
    logic        sd_cmd_oe;
    logic        sd_cmd_in;

    // Card control and what the card saw
    logic        answer;
    logic [47:0] resp_word;
    logic [47:0] cmd_token;
    int          half_time;

    // Word 0 holds the line count, then eight words per command
    logic [31:0] stim [0:fields*max_lines];
    int          line_count;
    int          cycle_limit = 0;
    int          cycle_count = 0;

    sd_host_top sd_host_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (we),
        .re         (re),
        .waddr      (waddr),
        .raddr      (raddr),
        .wdata      (wdata),
        .rdata      (rdata),
        .interrupt  (interrupt),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in)
    );

    sd_card_model sd_card_model_inst (
        .clk        (clk),
        .sd_clk     (sd_clk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .answer     (answer),
        .resp_word  (resp_word),
        .sd_cmd_in  (sd_cmd_in),
        .cmd_token  (cmd_token),
        .half_time  (half_time)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            $display("Timeout: command sequence not finished after %0d cycles", cycle_count);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_status(input string name, input logic [4:0] expected,
                                input logic [4:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_token(input string name, input sd_host_pkg::resp_token_t expected,
                               input sd_host_pkg::resp_token_t actual);
        if (actual.raw !== expected.raw) begin
            $display("ERROR %s expected %h actual %h", name, expected.raw, actual.raw);
            report_failure();
        end
    endtask

    // CRC7 as an LFSR, x^7 + x^3 + 1, taps on bits 3 and 0
    function automatic logic [6:0] crc7_serial(input logic [39:0] bits);
        logic [6:0] r;
        logic       fb;
        r = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ r[6];
            r  = {r[5], r[4], r[3], r[2] ^ fb, r[1], r[0], fb};
        end
        return r;
    endfunction

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        we    = 1'b1;
        waddr = addr;
        wdata = data;
        @(negedge clk);
        we = 1'b0;
    endtask

    // rdata is combinational, sampled inside the low clock phase
    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        re    = 1'b1;
        raddr = addr;
        #2;
        data = rdata;
    endtask

    task automatic wait_done(output logic [31:0] status);
        status = '0;
        while (!status[sd_host_pkg::st_done]) begin
            read_reg(sd_host_pkg::addr_status, status);
        end
    endtask

    task automatic run_line(input int n);
        logic [7:0]               div;
        logic [5:0]               idx;
        logic [31:0]              arg;
        logic [1:0]               rtype;
        logic [1:0]               chk;
        logic [1:0]               action;
        logic [31:0]              rarg;
        logic [4:0]               exp_status;
        logic [31:0]              cmd_word;
        logic [39:0]              head;
        logic [5:0]               rindex;
        logic [6:0]               rcrc;
        logic [31:0]              data;
        sd_host_pkg::resp_token_t exp_token;
        string                    tag;
        int                       base;
        base       = 1 + n * fields;
        div        = stim[base][7:0];
        idx        = stim[base + 1][5:0];
        arg        = stim[base + 2];
        rtype      = stim[base + 3][1:0];
        chk        = stim[base + 4][1:0];
        action     = stim[base + 5][1:0];
        rarg       = stim[base + 6];
        exp_status = stim[base + 7][4:0];
        tag        = $sformatf("line %0d", n);

        cmd_word = {20'd0, chk, rtype, 2'd0, idx};
        write_reg(sd_host_pkg::addr_cmd, cmd_word);
        write_reg(sd_host_pkg::addr_arg, arg);
        write_reg(sd_host_pkg::addr_clk_div, {24'd0, div});
        read_reg(sd_host_pkg::addr_cmd, data);
        check_word({tag, " CMD readback"}, cmd_word, data);
        read_reg(sd_host_pkg::addr_arg, data);
        check_word({tag, " ARG readback"}, arg, data);
        read_reg(sd_host_pkg::addr_clk_div, data);
        check_word({tag, " CLK_DIV readback"}, {24'd0, div}, data);

        // Token on the line: start 0, direction 1, CRC over the first 40 bits
        head          = {2'b01, idx, arg};
        exp_token.raw = {head, crc7_serial(head), 1'b1};

        // Card response: correct, CRC inverted, or index changed
        rindex = (action == 2'd2) ? (idx ^ 6'h01) : idx;
        rcrc   = crc7_serial({2'b00, rindex, rarg});
        if (action == 2'd1) begin
            rcrc = ~rcrc;
        end
        @(negedge clk);
        answer    = (action != 2'd3);
        resp_word = {2'b00, rindex, rarg, rcrc, 1'b1};

        write_reg(sd_host_pkg::addr_control, 32'h1);
        wait_done(data);
        check_status({tag, " status"}, exp_status, data[4:0]);
        check_word({tag, " interrupt"}, 32'h1, {31'd0, interrupt});
        read_reg(sd_host_pkg::addr_control, data);
        check_word({tag, " start bit"}, 32'h0, data);
        check_token({tag, " command token"}, exp_token, cmd_token);
        check_word({tag, " sd_clk half period"}, (32'(div) + 32'd1) * 32'd8, half_time);
        if (action != 2'd3) begin
            read_reg(sd_host_pkg::addr_resp_lo, data);
            check_word({tag, " RESP_LO"}, rarg, data);
            read_reg(sd_host_pkg::addr_resp_hi, data);
            check_word({tag, " RESP_HI"}, {17'd0, rcrc, 2'd0, rindex}, data);
        end

        // Write ones to clear every sticky bit
        write_reg(sd_host_pkg::addr_status, 32'h1F);
        read_reg(sd_host_pkg::addr_status, data);
        check_status({tag, " status after clear"}, 5'd0, data[4:0]);
        check_word({tag, " interrupt after clear"}, 32'h0, {31'd0, interrupt});
    endtask

    initial begin
        logic [31:0] data;
        int          max_div;
        clk       = 1'b0;
        rst_n     = 1'b0;
        we        = 1'b0;
        re        = 1'b0;
        waddr     = '0;
        raddr     = '0;
        wdata     = '0;
        answer    = 1'b0;
        resp_word = '1;

        $readmemh("testbench/sd_host_stimulus.txt", stim);
        line_count = int'(stim[0]);
        if ((line_count < 1) || (line_count > max_lines)) begin
            $display("Stimulus file has no valid line count");
            report_failure();
        end
        max_div = 0;
        for (int n = 0; n < line_count; n++) begin
            if (int'(stim[1 + n * fields][7:0]) > max_div) begin
                max_div = int'(stim[1 + n * fields][7:0]);
            end
        end
        // Token out, longest wait and response in, two halves per SD clock
        cycle_limit = line_count * (2 * 48 + 64) * 2 * (max_div + 1) + line_count * 200 + 1000;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_reg(sd_host_pkg::addr_clk_div, data);
        check_word("reset CLK_DIV", 32'h2, data);
        read_reg(sd_host_pkg::addr_cmd, data);
        check_word("reset CMD", 32'hD00, data);
        read_reg(sd_host_pkg::addr_status, data);
        check_status("reset status", 5'd0, data[4:0]);
        check_word("reset interrupt", 32'h0, {31'd0, interrupt});

        for (int n = 0; n < line_count; n++) begin
            run_line(n);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sd_host_stimulus.txt */
// First word: number of command lines. Columns, all hex: clk_div index arg resp_type
// checks (bit 1 CRC, bit 0 index) card_action (0 ok 1 bad CRC 2 bad index 3 silent) resp_arg status
9
02 11 00001000 1 3 0 00000900 01
00 0D 12340000 1 3 1 00000A5A 09
01 37 00000000 1 3 2 00000120 11
02 29 40FF8000 2 3 1 80FF8000 01
03 0D 12340000 1 0 1 00000A5A 01
01 37 00000000 1 2 2 00000120 01
04 08 000001AA 1 3 3 00000000 05
00 00 00000000 0 3 3 00000000 01
07 03 00000000 1 3 0 ABCD0500 01

/* all.f */
rtl/sd_host_pkg.sv
rtl/sd_reg_block.sv
rtl/sd_cmd_engine.sv
rtl/sd_cmd_serdes.sv
rtl/sd_host_top.sv
testbench/sd_card_model.sv
testbench/sd_host_assert.sv
testbench/tb_sd_host.sv

/* Makefile */
# Verilator build and run for the SD host command path

VERILATOR ?= verilator
TOP       ?= tb_sd_host
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SRCS := $(wildcard rtl/*.sv testbench/*.sv)
STIM := testbench/sd_host_stimulus.txt
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM) $(STIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
